//--- rv_isa_pkg.sv
// RV32I subset instruction-set definitions
//   major opcodes, funct3 and funct7 codes
//   ecall selector values
//   per-format field structs and the instruction word union
package rv_isa_pkg;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;

    // x17 values on ecall
    localparam logic [31:0] ecall_print = 32'd1;
    localparam logic [31:0] ecall_exit  = 32'd93;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_t;

endpackage

//--- core_pkg.sv
// pico pipeline definitions
//   reset pc and fixed register indices
//   ALU operation enum
//   stage-to-stage structs, jump and register write records
package core_pkg;

    localparam logic [31:0] start_addr = 32'h0000_0000;

    // ecall argument registers
    localparam logic [4:0] reg_a0 = 5'd10;
    localparam logic [4:0] reg_a7 = 5'd17;

    // exit code reported for an unknown opcode
    localparam logic [31:0] illegal_exit_code = 32'd255;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_op_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     alu_op;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        reg_idx_t    rd;
        logic        write_en;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jal;
        logic [31:0] pc;
        logic [31:0] imm_target;
        logic        is_ecall;
        logic [31:0] ecall_sel;
        logic [31:0] ecall_arg;
    } exec_op_t;

    typedef struct packed {
        logic        valid;
        reg_idx_t    rd;
        logic        write_en;
        logic [31:0] value;
        logic        is_ecall;
        logic [31:0] ecall_sel;
        logic [31:0] ecall_arg;
    } result_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } jump_t;

    typedef struct packed {
        logic        valid;
        reg_idx_t    rd;
        logic [31:0] value;
    } reg_write_t;

endpackage

//--- core_fetch.sv
// fetch stage
//   program counter with jump redirect and halt freeze
//   instruction address and the matching in-flight fetch tag
module core_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::jump_t     jump,
    input  logic                halted,
    output logic [31:0]         inst_addr,
    output core_pkg::fetch_op_t fetch_op
);
    import core_pkg::*;

    logic [31:0] pc;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= start_addr;
        end else if (halted) begin
            pc <= pc;
        end else if (jump.valid) begin
            pc <= jump.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // tag follows the address by one cycle, like the memory data
    always_ff @(posedge clk) begin
        fetch_op.pc <= pc;
        if (!rst_n) begin
            fetch_op.valid <= 1'b0;
        end else begin
            fetch_op.valid <= !jump.valid && !halted;
        end
    end

endmodule

//--- core_decode.sv
// decode stage
//   format decode and immediate generation
//   32-entry register file with two-level forwarding
//   ecall argument reads, illegal opcode to exit
//   squash of wrong-path fetches on a jump
module core_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::fetch_op_t  fetch_op,
    input  logic [31:0]          inst_data,
    input  core_pkg::jump_t      jump,
    input  core_pkg::reg_write_t fwd_exec,
    input  core_pkg::reg_write_t reg_write,
    output core_pkg::exec_op_t   exec_op
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    rv_inst_t    inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] a0_val;
    logic [31:0] a7_val;
    logic [31:0] regs [32];
    exec_op_t    next_op;

    // newest value wins, x0 stays zero
    function automatic logic [31:0] read_fwd(reg_idx_t idx, logic [31:0] rf_val,
                                             reg_write_t ex, reg_write_t wb);
        if (idx == '0) begin
            return '0;
        end
        if (ex.valid && ex.rd == idx) begin
            return ex.value;
        end
        if (wb.valid && wb.rd == idx) begin
            return wb.value;
        end
        return rf_val;
    endfunction

    function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic sub);
        case (f3)
            f3_add_sub: return sub ? alu_sub : alu_add;
            f3_slt:     return alu_slt;
            f3_xor:     return alu_xor;
            f3_or:      return alu_or;
            f3_and:     return alu_and;
            default:    return alu_add;
        endcase
    endfunction

    assign inst   = inst_data;
    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    assign rs1_val = read_fwd(inst.r.rs1, regs[inst.r.rs1], fwd_exec, reg_write);
    assign rs2_val = read_fwd(inst.r.rs2, regs[inst.r.rs2], fwd_exec, reg_write);
    assign a0_val  = read_fwd(reg_a0, regs[reg_a0], fwd_exec, reg_write);
    assign a7_val  = read_fwd(reg_a7, regs[reg_a7], fwd_exec, reg_write);

    always_comb begin
        next_op            = '0;
        next_op.valid      = fetch_op.valid && !jump.valid;
        next_op.pc         = fetch_op.pc;
        next_op.rd         = inst.r.rd;
        next_op.alu_op     = alu_add;
        next_op.operand_a  = rs1_val;
        next_op.operand_b  = rs2_val;
        next_op.imm_target = fetch_op.pc + imm_b;
        next_op.ecall_sel  = a7_val;
        next_op.ecall_arg  = a0_val;
        case (opcode)
            opc_op: begin
                next_op.write_en = 1'b1;
                next_op.alu_op   = alu_from_f3(funct3, inst.r.funct7 == f7_sub);
            end
            opc_op_imm: begin
                next_op.write_en  = 1'b1;
                next_op.operand_b = imm_i;
                next_op.alu_op    = alu_from_f3(funct3, 1'b0);
            end
            opc_lui: begin
                next_op.write_en  = 1'b1;
                next_op.operand_b = imm_u;
                next_op.alu_op    = alu_pass_b;
            end
            opc_branch: begin
                next_op.is_branch = (funct3 == f3_beq) || (funct3 == f3_bne);
                next_op.branch_ne = (funct3 == f3_bne);
            end
            opc_jal: begin
                next_op.write_en   = 1'b1;
                next_op.is_jal     = 1'b1;
                next_op.imm_target = fetch_op.pc + imm_j;
            end
            opc_system: begin
                next_op.is_ecall = 1'b1;
            end
            default: begin
                // retire as a faulting exit
                next_op.is_ecall  = 1'b1;
                next_op.ecall_sel = ecall_exit;
                next_op.ecall_arg = illegal_exit_code;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.valid && reg_write.rd != '0) begin
            regs[reg_write.rd] <= reg_write.value;
        end
    end

    always_ff @(posedge clk) begin
        exec_op <= next_op;
        if (!rst_n) begin
            exec_op.valid <= 1'b0;
        end
    end

endmodule

//--- core_execute.sv
// execute stage
//   ALU with signed set-less-than and pass-through of operand b
//   branch compare and jump request toward fetch and decode
//   forwarding of the current result, result register to writeback
module core_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::exec_op_t   exec_op,
    output core_pkg::jump_t      jump,
    output core_pkg::reg_write_t fwd_exec,
    output core_pkg::result_t    result
);
    import core_pkg::*;

    logic [31:0] alu_out;
    logic [31:0] value;
    logic        taken;
    result_t     next_result;

    always_comb begin
        case (exec_op.alu_op)
            alu_add:    alu_out = exec_op.operand_a + exec_op.operand_b;
            alu_sub:    alu_out = exec_op.operand_a - exec_op.operand_b;
            alu_and:    alu_out = exec_op.operand_a & exec_op.operand_b;
            alu_or:     alu_out = exec_op.operand_a | exec_op.operand_b;
            alu_xor:    alu_out = exec_op.operand_a ^ exec_op.operand_b;
            alu_slt: begin
                alu_out = {31'b0, $signed(exec_op.operand_a) < $signed(exec_op.operand_b)};
            end
            alu_pass_b: alu_out = exec_op.operand_b;
            default:    alu_out = exec_op.operand_a + exec_op.operand_b;
        endcase
    end

    // jal links the next sequential pc
    assign value = exec_op.is_jal ? exec_op.pc + 32'd4 : alu_out;

    // equality, flipped for bne
    assign taken = exec_op.is_jal ||
                   (exec_op.is_branch &&
                    ((exec_op.operand_a == exec_op.operand_b) ^ exec_op.branch_ne));

    assign jump.valid  = exec_op.valid && taken;
    assign jump.target = exec_op.imm_target;

    assign fwd_exec.valid = exec_op.valid && exec_op.write_en;
    assign fwd_exec.rd    = exec_op.rd;
    assign fwd_exec.value = value;

    always_comb begin
        next_result.valid     = exec_op.valid;
        next_result.rd        = exec_op.rd;
        next_result.write_en  = exec_op.write_en;
        next_result.value     = value;
        next_result.is_ecall  = exec_op.is_ecall;
        next_result.ecall_sel = exec_op.ecall_sel;
        next_result.ecall_arg = exec_op.ecall_arg;
    end

    always_ff @(posedge clk) begin
        result <= next_result;
        if (!rst_n) begin
            result.valid <= 1'b0;
        end
    end

endmodule

//--- core_writeback.sv
// writeback stage
//   register write toward the register file and decode forwarding
//   print strobe, exit flags and halt
module core_writeback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::result_t    result,
    output core_pkg::reg_write_t reg_write,
    output logic                 print_valid,
    output logic [7:0]           print_char,
    output logic                 finished_flag,
    output logic                 faulted_flag,
    output logic                 halted
);
    import rv_isa_pkg::*;

    logic active;
    logic do_print;
    logic do_exit;

    // nothing retires once an exit has been taken
    assign halted   = finished_flag || faulted_flag;
    assign active   = result.valid && !halted;
    assign do_print = active && result.is_ecall && (result.ecall_sel == ecall_print);
    assign do_exit  = active && result.is_ecall && (result.ecall_sel == ecall_exit);

    assign reg_write.valid = active && result.write_en;
    assign reg_write.rd    = result.rd;
    assign reg_write.value = result.value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            print_valid   <= 1'b0;
            finished_flag <= 1'b0;
            faulted_flag  <= 1'b0;
        end else begin
            print_valid <= do_print;
            if (do_exit) begin
                finished_flag <= (result.ecall_arg == '0);
                faulted_flag  <= (result.ecall_arg != '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_print) begin
            print_char <= result.ecall_arg[7:0];
        end
    end

endmodule

//--- core_top.sv
// pico core top level
//   fetch, decode, execute and writeback instances
//   jump, forwarding and halt connections between stages
module core_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_data,
    output logic        print_valid,
    output logic [7:0]  print_char,
    output logic        finished_flag,
    output logic        faulted_flag
);
    import core_pkg::*;

    fetch_op_t  fetch_op;
    exec_op_t   exec_op;
    result_t    result;
    jump_t      jump;
    reg_write_t fwd_exec;
    reg_write_t reg_write;
    logic       halted;

    core_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .jump      (jump),
        .halted    (halted),
        .inst_addr (inst_addr),
        .fetch_op  (fetch_op)
    );

    core_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_op  (fetch_op),
        .inst_data (inst_data),
        .jump      (jump),
        .fwd_exec  (fwd_exec),
        .reg_write (reg_write),
        .exec_op   (exec_op)
    );

    core_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .exec_op  (exec_op),
        .jump     (jump),
        .fwd_exec (fwd_exec),
        .result   (result)
    );

    core_writeback u_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .result        (result),
        .reg_write     (reg_write),
        .print_valid   (print_valid),
        .print_char    (print_char),
        .finished_flag (finished_flag),
        .faulted_flag  (faulted_flag),
        .halted        (halted)
    );

endmodule

//--- core_asserts.sv
// concurrent checks bound to the core top level
//   word-aligned fetch address
//   exclusive and sticky exit flags
//   quiet print strobe after reset
module core_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] inst_addr,
    input logic        print_valid,
    input logic        finished_flag,
    input logic        faulted_flag
);
    timeunit 1ns;
    timeprecision 100ps;

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n) inst_addr[1:0] == 2'b00)
        else $error("instruction address is not word aligned");

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(finished_flag && faulted_flag))
        else $error("finished_flag and faulted_flag are high together");

    finished_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        finished_flag |=> finished_flag)
        else $error("finished_flag dropped without a reset");

    faulted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        faulted_flag |=> faulted_flag)
        else $error("faulted_flag dropped without a reset");

    print_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !print_valid)
        else $error("print_valid high in the cycle after reset");

endmodule

bind core_top core_asserts u_asserts (.*);

//--- tb_checker.sv
// testbench checker
//   ISA reference model over the program image
//   print stream and exit flag comparison, timeout per test
//   per-test report and pass and fail counts
module tb_checker (
    input  logic        clk,
    input  logic        start,
    input  int          test_id,
    input  logic [31:0] prog [64],
    input  logic        print_valid,
    input  logic [7:0]  print_char,
    input  logic        finished_flag,
    input  logic        faulted_flag,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_isa_pkg::*;

    localparam int step_limit = 1000;

    logic [7:0]  exp_bytes [$];
    logic [31:0] exp_code;
    logic        exp_exit;
    int          exp_steps;

    function automatic logic [31:0] isa_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            f3_add_sub: return sub ? a - b : a + b;
            f3_slt:     return {31'b0, $signed(a) < $signed(b)};
            f3_xor:     return a ^ b;
            f3_or:      return a | b;
            f3_and:     return a & b;
            default:    return a + b;
        endcase
    endfunction

    // steps the program from address 0 until an exit
    function void run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        wr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        exp_bytes.delete();
        exp_code  = '0;
        exp_exit  = 1'b0;
        exp_steps = 0;
        pc        = '0;
        while (!exp_exit && exp_steps < step_limit) begin
            w       = prog[pc[7:2]];
            rd      = w[11:7];
            f3      = w[14:12];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            val     = '0;
            exp_steps++;
            case (w[6:0])
                opc_op: begin
                    wr  = 1'b1;
                    val = isa_alu(f3, w[30], a, b);
                end
                opc_op_imm: begin
                    wr  = 1'b1;
                    val = isa_alu(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
                end
                opc_lui: begin
                    wr  = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                opc_branch: begin
                    if ((f3 == f3_beq && a == b) || (f3 == f3_bne && a != b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                opc_jal: begin
                    wr      = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                opc_system: begin
                    if (regs[17] == ecall_print) begin
                        exp_bytes.push_back(regs[10][7:0]);
                    end else if (regs[17] == ecall_exit) begin
                        exp_exit = 1'b1;
                        exp_code = regs[10];
                    end
                end
                default: begin
                    exp_exit = 1'b1;
                    exp_code = 32'd255;
                end
            endcase
            if (wr && rd != 5'd0) begin
                regs[rd] = val;
            end
            pc = next_pc;
        end
    endfunction

    task automatic run_test();
        int   cycles;
        int   limit;
        int   idx;
        logic ok;
        logic stop;
        logic exp_fin;
        run_reference();
        ok      = 1'b1;
        stop    = 1'b0;
        idx     = 0;
        cycles  = 0;
        limit   = 3 * exp_steps + 40;
        exp_fin = (exp_code == 32'd0);
        if (!exp_exit) begin
            $display("test %0d: reference program never reaches an exit", test_id);
            ok = 1'b0;
        end
        while (!stop) begin
            @(negedge clk);
            cycles++;
            if (print_valid) begin
                if (idx >= exp_bytes.size()) begin
                    $display("test %0d: unexpected extra print byte 0x%02h", test_id, print_char);
                    ok = 1'b0;
                end else begin
                    if (print_char !== exp_bytes[idx]) begin
                        $display("ERR %0t print_char expected 0x%02h actual 0x%02h",
                                 $time, exp_bytes[idx], print_char);
                        ok = 1'b0;
                    end
                    idx++;
                end
            end
            if (finished_flag || faulted_flag) begin
                if (finished_flag !== exp_fin) begin
                    $display("ERR %0t finished_flag expected %0b actual %0b",
                             $time, exp_fin, finished_flag);
                    ok = 1'b0;
                end
                if (faulted_flag !== !exp_fin) begin
                    $display("ERR %0t faulted_flag expected %0b actual %0b",
                             $time, !exp_fin, faulted_flag);
                    ok = 1'b0;
                end
                if (idx != exp_bytes.size()) begin
                    $display("test %0d: only %0d of %0d bytes printed before the exit",
                             test_id, idx, exp_bytes.size());
                    ok = 1'b0;
                end
                // nothing may print once halted
                repeat (8) begin
                    @(negedge clk);
                    if (print_valid) begin
                        $display("test %0d: print strobe seen after the exit", test_id);
                        ok = 1'b0;
                    end
                end
                stop = 1'b1;
            end else if (cycles > limit) begin
                $display("test %0d: timeout, no exit within %0d cycles", test_id, limit);
                ok   = 1'b0;
                stop = 1'b1;
            end
        end
        if (ok) begin
            pass_count++;
            $display("test %0d: pass (%0d bytes, %0d instructions)", test_id, idx, exp_steps);
        end else begin
            fail_count++;
            $display("test %0d: fail", test_id);
        end
    endtask

    initial begin
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        forever begin
            wait (start);
            run_test();
            done = 1'b1;
            wait (!start);
            done = 1'b0;
        end
    end

endmodule

//--- tb_top.sv
// testbench top for the pico core
//   clock, reset and one-cycle instruction memory
//   instruction encoders and xorshift random source
//   test programs and final verdict
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_isa_pkg::*;

    localparam int num_tests = 7;
    localparam logic [31:0] ecall_word = 32'h0000_0073;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic [31:0] addr_q;
    logic        print_valid;
    logic [7:0]  print_char;
    logic        finished_flag;
    logic        faulted_flag;
    logic        start;
    logic        done;
    int          test_id;
    int          pass_count;
    int          fail_count;
    logic [31:0] prog [64];
    logic [31:0] rng;
    logic [5:0]  wp;

    core_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .print_valid   (print_valid),
        .print_char    (print_char),
        .finished_flag (finished_flag),
        .faulted_flag  (faulted_flag)
    );

    tb_checker u_checker (
        .clk           (clk),
        .start         (start),
        .test_id       (test_id),
        .prog          (prog),
        .print_valid   (print_valid),
        .print_char    (print_char),
        .finished_flag (finished_flag),
        .faulted_flag  (faulted_flag),
        .done          (done),
        .pass_count    (pass_count),
        .fail_count    (fail_count)
    );

    always #2 clk = ~clk;

    // address taken at the rising edge and data returned one cycle later
    always @(posedge clk) begin
        addr_q <= inst_addr;
    end

    always @(negedge clk) begin
        inst_data <= prog[addr_q[7:2]];
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] random_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function logic [4:0] random_reg();
        return 5'(32'd1 + random_word() % 32'd9);
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1,
                                               logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    task automatic emit(logic [31:0] w);
        prog[wp] = w;
        wp       = wp + 6'd1;
    endtask

    // every word a nop that carries its own index
    task automatic begin_program();
        for (int i = 0; i < 64; i++) begin
            prog[i[5:0]] = enc_i(f3_add_sub, 5'd0, 5'd0, 12'(i));
        end
        wp = '0;
    endtask

    task automatic put_reg(logic [4:0] rd, logic [11:0] imm);
        emit(enc_i(f3_add_sub, rd, 5'd0, imm));
    endtask

    task automatic print_reg(logic [4:0] r);
        emit(enc_i(f3_add_sub, 5'd10, r, 12'd0));
        put_reg(5'd17, 12'd1);
        emit(ecall_word);
    endtask

    task automatic exit_with(logic [11:0] code);
        put_reg(5'd10, code);
        put_reg(5'd17, 12'd93);
        emit(ecall_word);
    endtask

    task automatic random_op();
        logic [31:0] sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] r;
        sel = random_word() % 32'd12;
        rd  = random_reg();
        rs1 = random_reg();
        rs2 = random_reg();
        r   = random_word();
        case (sel)
            0:       emit(enc_r(f7_add, f3_add_sub, rd, rs1, rs2));
            1:       emit(enc_r(f7_sub, f3_add_sub, rd, rs1, rs2));
            2:       emit(enc_r(f7_add, f3_and, rd, rs1, rs2));
            3:       emit(enc_r(f7_add, f3_or, rd, rs1, rs2));
            4:       emit(enc_r(f7_add, f3_xor, rd, rs1, rs2));
            5:       emit(enc_r(f7_add, f3_slt, rd, rs1, rs2));
            6:       emit(enc_i(f3_add_sub, rd, rs1, r[11:0]));
            7:       emit(enc_i(f3_and, rd, rs1, r[11:0]));
            8:       emit(enc_i(f3_or, rd, rs1, r[11:0]));
            9:       emit(enc_i(f3_xor, rd, rs1, r[11:0]));
            10:      emit(enc_i(f3_slt, rd, rs1, r[11:0]));
            default: emit({r[19:0], rd, opc_lui});
        endcase
    endtask

    task automatic build_random();
        begin_program();
        for (int i = 1; i < 10; i++) begin
            put_reg(i[4:0], 12'(random_word()));
        end
        repeat (6) begin
            random_op();
            random_op();
            print_reg(random_reg());
        end
        exit_with(12'd0);
    endtask

    task automatic build_forwarding();
        begin_program();
        put_reg(5'd1, 12'(random_word()));
        emit(enc_r(f7_add, f3_add_sub, 5'd2, 5'd1, 5'd1));
        emit(enc_i(f3_xor, 5'd3, 5'd1, 12'h5a5));
        emit(enc_r(f7_sub, f3_add_sub, 5'd4, 5'd2, 5'd1));
        emit(enc_r(f7_add, f3_xor, 5'd5, 5'd3, 5'd2));
        emit({20'h12345, 5'd7, opc_lui});
        put_reg(5'd0, 12'd0);
        put_reg(5'd0, 12'd0);
        emit(enc_i(f3_or, 5'd8, 5'd7, 12'h0c3));
        for (int r = 2; r < 9; r++) begin
            print_reg(r[4:0]);
        end
        exit_with(12'd0);
    endtask

    task automatic build_branches();
        begin_program();
        put_reg(5'd1, 12'd3);
        put_reg(5'd2, 12'd3);
        put_reg(5'd3, 12'd9);
        put_reg(5'd10, 12'h41);
        put_reg(5'd17, 12'd1);
        emit(enc_branch(f3_beq, 5'd1, 5'd2, 13'd12));
        emit(ecall_word);
        emit(ecall_word);
        emit(enc_branch(f3_bne, 5'd1, 5'd2, 13'd12));
        emit(ecall_word);
        emit(ecall_word);
        put_reg(5'd10, 12'h42);
        emit(enc_branch(f3_bne, 5'd1, 5'd3, 13'd12));
        emit(ecall_word);
        emit(ecall_word);
        emit(enc_branch(f3_beq, 5'd1, 5'd3, 13'd12));
        emit(ecall_word);
        emit(ecall_word);
        emit(enc_jal(5'd5, 21'd12));
        emit(ecall_word);
        emit(ecall_word);
        print_reg(5'd5);
        exit_with(12'd0);
    endtask

    task automatic build_exit(logic [11:0] code, logic illegal);
        begin_program();
        put_reg(5'd6, 12'(random_word()));
        print_reg(5'd6);
        if (illegal) begin
            emit(32'h0000_0000);
        end else begin
            exit_with(code);
        end
        put_reg(5'd17, 12'd1);
        emit(ecall_word);
        print_reg(5'd6);
    endtask

    task automatic build_loop();
        logic [31:0] n;
        n = 32'd5 + random_word() % 32'd6;
        begin_program();
        put_reg(5'd1, 12'h030);
        put_reg(5'd2, 12'(32'h30 + n));
        emit(enc_i(f3_add_sub, 5'd1, 5'd1, 12'd1));
        print_reg(5'd1);
        emit(enc_branch(f3_bne, 5'd1, 5'd2, -13'sd16));
        exit_with(12'd0);
    endtask

    task automatic run_program(int id);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n   = 1'b1;
        test_id = id;
        start   = 1'b1;
        wait (done);
        @(negedge clk);
        start = 1'b0;
        wait (!done);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst_data = '0;
        addr_q    = '0;
        start     = 1'b0;
        test_id   = 0;
        rng       = 32'h8214_2e5b;
        build_random();
        run_program(1);
        build_forwarding();
        run_program(2);
        build_branches();
        run_program(3);
        build_exit(12'd0, 1'b0);
        run_program(4);
        build_exit(12'(32'd1 + random_word() % 32'd200), 1'b0);
        run_program(5);
        build_exit(12'd0, 1'b1);
        run_program(6);
        build_loop();
        run_program(7);
        $display("tests run %0d, passed %0d, failed %0d",
                 num_tests, pass_count, fail_count);
        if (fail_count == 0 && pass_count == num_tests) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
rv_isa_pkg.sv
core_pkg.sv
core_fetch.sv
core_decode.sv
core_execute.sv
core_writeback.sv
core_top.sv
core_asserts.sv
tb_checker.sv
tb_top.sv

//--- Makefile
# Verilator build and run for the pico core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
